/* hdl/memPkg.sv */
package memPkg;

  // Basic computer word and address widths
  typedef logic [11:0] wordAddr_t;
  typedef logic [15:0] word_t;

  typedef struct packed {
    wordAddr_t addr;
    word_t     wdata;
    logic      write;
  } memReq_t;

  typedef enum logic [1:0] {
    rom,
    ram,
    periph,
    none
  } memTarget_e;

  // Word toward the serial transmitter
  typedef struct packed {
    logic  valid;
    word_t data;
  } txWord_t;

  typedef enum logic [1:0] {
    idle,
    access,
    respond
  } portState_e;

  // Address map
  localparam wordAddr_t romBase     = 12'h000;
  localparam int        romWords    = 32;
  localparam wordAddr_t periphBase  = 12'h050;
  localparam int        periphWords = 4;
  localparam wordAddr_t ramBase     = 12'h100;

endpackage

/* hdl/wbMemPort.sv */
`timescale 1ns/1ns

module wbMemPort import memPkg::*; #(
  parameter int ramAddrWidth = 8
) (
  input  logic      romclk,
  input  logic      rst,
  input  logic      cyc,
  input  logic      stb,
  input  logic      we,
  input  wordAddr_t adr,
  input  word_t     datIn,
  output word_t     datOut,
  output logic      ack,
  output memReq_t   req,
  output logic      romSel,
  output logic      ramSel,
  output logic      periphSel,
  input  word_t     romData,
  input  word_t     ramData,
  input  word_t     periphData
);

  localparam int ramTop = int'(ramBase) + (1 << ramAddrWidth);

  portState_e state;
  memTarget_e target;
  memTarget_e decoded;
  logic       start;

  assign start = (state == idle) && cyc && stb && !ack;

  always_comb begin
    if (int'(adr) >= int'(romBase) && int'(adr) < int'(romBase) + romWords) begin
      decoded = rom;
    end else if (int'(adr) >= int'(periphBase) &&
                 int'(adr) < int'(periphBase) + periphWords) begin
      decoded = periph;
    end else if (int'(adr) >= int'(ramBase) && int'(adr) < ramTop) begin
      decoded = ram;
    end else begin
      decoded = none; // Unmapped but still acknowledged
    end
  end

  always_ff @(posedge romclk or posedge rst) begin
    if (rst) begin
      state  <= idle;
      target <= none;
    end else begin
      unique case (state)
        idle: begin
          if (start) begin
            state  <= access;
            target <= decoded;
          end
        end
        access:  state <= respond;
        respond: state <= idle;
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge romclk) begin
    if (start) begin
      req <= '{addr: adr, wdata: datIn, write: we}; // Held for the access cycle
    end
  end

  assign romSel    = (state == access) && (target == rom);
  assign ramSel    = (state == access) && (target == ram);
  assign periphSel = (state == access) && (target == periph);
  assign ack       = (state == respond);

  always_comb begin
    datOut = '0;
    if (state == respond) begin
      unique case (target)
        rom:     datOut = romData;
        ram:     datOut = ramData;
        periph:  datOut = periphData;
        default: datOut = '0;
      endcase
    end
  end

endmodule

/* hdl/bootRom.sv */
`timescale 1ns/1ns

module bootRom import memPkg::*; (
  input  logic       romclk,
  input  logic       rst,
  input  logic       sel,
  input  logic [4:0] addr,
  output word_t      data
);

  word_t romWord;

  // Start-up program
  always_comb begin
    unique case (addr)
      5'h00: romWord = 16'hF200; // SKI
      5'h01: romWord = 16'h4000; // BUN back to SKI
      5'h02: romWord = 16'hF800; // INP
      5'h03: romWord = 16'h1007; // ADD 07
      5'h04: romWord = 16'hF400; // OUT
      5'h05: romWord = 16'h3050; // STA to transmit register
      5'h06: romWord = 16'h7010; // SPA
      5'h07: romWord = 16'h0011; // Operand
      5'h08: romWord = 16'h2007; // LDA 07
      5'h09: romWord = 16'h000B; // AND 0B
      5'h0A: romWord = 16'h7004; // SZA
      5'h0B: romWord = 16'h0050; // Pointer to transmit register
      5'h0C: romWord = 16'hA007; // LDA indirect 07
      5'h0D: romWord = 16'h9011; // ADD indirect 11
      5'h0E: romWord = 16'hB00B; // STA indirect through 0B
      5'h0F: romWord = 16'h7200; // CMA
      5'h10: romWord = 16'h7008; // SNA
      5'h11: romWord = 16'h0007; // Pointer
      5'h12: romWord = 16'h7080; // CIR
      5'h13: romWord = 16'hF400; // OUT
      5'h14: romWord = 16'h7400; // CLE
      5'h15: romWord = 16'h7040; // CIL
      5'h16: romWord = 16'hF400; // OUT
      5'h17: romWord = 16'h7020; // INC
      5'h18: romWord = 16'h7100; // CME
      5'h19: romWord = 16'h7040; // CIL
      5'h1A: romWord = 16'hF400; // OUT
      5'h1B: romWord = 16'h501E; // BSA 1E
      5'h1C: romWord = 16'h6051; // ISZ on the counter word
      5'h1D: romWord = 16'h7001; // HLT
      5'h1E: romWord = 16'h001C; // Return address slot
      5'h1F: romWord = 16'hC01E; // BUN indirect 1E
      default: romWord = '0;
    endcase
  end

  always_ff @(posedge romclk or posedge rst) begin
    if (rst) begin
      data <= '0;
    end else if (sel) begin
      data <= romWord;
    end
  end

endmodule

/* hdl/dataRam.sv */
`timescale 1ns/1ns

module dataRam import memPkg::*; #(
  parameter int ramAddrWidth = 8
) (
  input  logic    romclk,
  input  logic    sel,
  input  memReq_t req,
  output word_t   data
);

  localparam int depth = 1 << ramAddrWidth;

  word_t                   mem [depth];
  logic [ramAddrWidth-1:0] index;

  assign index = req.addr[ramAddrWidth-1:0]; // Window offset

  always_ff @(posedge romclk) begin
    if (sel) begin
      if (req.write) begin
        mem[index] <= req.wdata;
      end else begin
        data <= mem[index];
      end
    end
  end

endmodule

/* hdl/periphRegs.sv */
`timescale 1ns/1ns

module periphRegs import memPkg::*; (
  input  logic    romclk,
  input  logic    rst,
  input  logic    sel,
  input  memReq_t req,
  output word_t   data,
  output txWord_t tx
);

  word_t      regs [4]; // 0 transmit, 1 counter, 2 and 3 scratch
  logic [1:0] offset;

  assign offset = req.addr[1:0];

  always_ff @(posedge romclk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < 4; i++) begin
        regs[i] <= '0;
      end
      data <= '0;
      tx   <= '0;
    end else begin
      tx.valid <= 1'b0; // One cycle pulse
      if (sel) begin
        if (req.write) begin
          regs[offset] <= req.wdata;
          if (offset == 2'd0) begin
            tx.valid <= 1'b1;
            tx.data  <= req.wdata;
          end
        end else begin
          data <= regs[offset];
        end
      end
    end
  end

endmodule

/* hdl/memSubsystem.sv */
`timescale 1ns/1ns

module memSubsystem import memPkg::*; #(
  parameter int ramAddrWidth = 8
) (
  input  logic      romclk,
  input  logic      rst,
  input  logic      cyc,
  input  logic      stb,
  input  logic      we,
  input  wordAddr_t adr,
  input  word_t     datIn,
  output word_t     datOut,
  output logic      ack,
  output txWord_t   tx
);

  memReq_t req;
  logic    romSel;
  logic    ramSel;
  logic    periphSel;
  word_t   romData;
  word_t   ramData;
  word_t   periphData;

  wbMemPort #(
    .ramAddrWidth(ramAddrWidth)
  ) i_port (
    .romclk    (romclk),
    .rst       (rst),
    .cyc       (cyc),
    .stb       (stb),
    .we        (we),
    .adr       (adr),
    .datIn     (datIn),
    .datOut    (datOut),
    .ack       (ack),
    .req       (req),
    .romSel    (romSel),
    .ramSel    (ramSel),
    .periphSel (periphSel),
    .romData   (romData),
    .ramData   (ramData),
    .periphData(periphData)
  );

  bootRom i_rom (
    .romclk(romclk),
    .rst   (rst),
    .sel   (romSel),
    .addr  (req.addr[4:0]),
    .data  (romData)
  );

  dataRam #(
    .ramAddrWidth(ramAddrWidth)
  ) i_ram (
    .romclk(romclk),
    .sel   (ramSel),
    .req   (req),
    .data  (ramData)
  );

  periphRegs i_periph (
    .romclk(romclk),
    .rst   (rst),
    .sel   (periphSel),
    .req   (req),
    .data  (periphData),
    .tx    (tx)
  );

endmodule

/* verification/memChecker.sv */
`timescale 1ns/1ns

module memChecker import memPkg::*; (
  input  logic      romclk,
  input  logic      rst,
  input  logic      cyc,
  input  logic      stb,
  input  logic      we,
  input  wordAddr_t adr,
  input  word_t     datOut,
  input  logic      ack,
  input  txWord_t   tx,
  input  word_t     expData,
  input  word_t     expTxData,
  input  int        txExpected,
  input  logic      testDone,
  input  int        testId,
  input  logic      allDone,
  output int        errors
);

  logic      pending;
  int        latency;
  wordAddr_t reqAddr;
  logic      reqWrite;
  int        txSeen;
  int        testErrors;
  int        tests;

  initial begin
    errors     = 0;
    pending    = 1'b0;
    latency    = 0;
    reqAddr    = '0;
    reqWrite   = 1'b0;
    txSeen     = 0;
    testErrors = 0;
    tests      = 0;
  end

  function automatic string testName(input int id);
    case (id)
      1:       return "reset and idle bus";
      2:       return "boot ROM";
      3:       return "data RAM";
      4:       return "peripheral registers";
      5:       return "unmapped addresses";
      default: return "unknown";
    endcase
  endfunction

  task automatic flagError();
    errors++;
    testErrors++;
  endtask

  // Sampled on the rising edge while inputs change on the falling one
  always @(posedge romclk) begin
    if (rst) begin
      if (ack || tx.valid) begin
        $display("ack or tx.valid went high during reset");
        flagError();
      end
      pending = 1'b0;
    end else begin
      if (tx.valid) begin
        txSeen++;
        if (tx.data !== expTxData) begin
          $display("CHECK FAILED tx.data: got %h expected %h", tx.data, expTxData);
          flagError();
        end
      end
      if (pending) begin
        latency++;
        if (ack) begin
          pending = 1'b0;
          if (latency != 2) begin
            $display("ack came %0d cycles after the request at %h instead of 2",
                     latency, reqAddr);
            flagError();
          end
          if (!reqWrite && datOut !== expData) begin
            $display("CHECK FAILED datOut at %h: got %h expected %h",
                     reqAddr, datOut, expData);
            flagError();
          end
        end else if (latency == 2) begin
          $display("No ack two cycles after the request at %h", reqAddr);
          flagError();
        end
      end else if (ack) begin
        $display("ack seen with no request outstanding");
        flagError();
      end else if (cyc && stb) begin
        pending  = 1'b1; // Request edge
        latency  = 0;
        reqAddr  = adr;
        reqWrite = we;
      end
    end
    if (testDone) begin
      tests++;
      if (txSeen != txExpected) begin
        $display("Saw %0d transmit pulses where %0d were expected", txSeen, txExpected);
        flagError();
      end
      if (testErrors == 0) begin
        $display("test %0d %s: ok", testId, testName(testId));
      end else begin
        $display("test %0d %s: FAILED (%0d errors)", testId, testName(testId), testErrors);
      end
      testErrors = 0;
    end
    if (allDone) begin
      $display("%0d tests run, %0d errors", tests, errors);
    end
  end

endmodule

/* verification/memSubsystemTb.sv */
`timescale 1ns/1ns

module memSubsystemTb import memPkg::*; ();

  localparam int ramAddrWidth = 8;
  localparam int ackTimeout   = 20; // Cycles allowed per bus cycle

  logic      romclk = 1'b0;
  logic      rst;
  logic      cyc;
  logic      stb;
  logic      we;
  wordAddr_t adr;
  word_t     datIn;
  word_t     datOut;
  logic      ack;
  txWord_t   tx;

  word_t     expData;
  word_t     expTxData;
  int        txExpected;
  logic      testDone;
  logic      allDone;
  int        testId;
  int        errors;
  logic      hung;
  integer    seed = 21;
  wordAddr_t ramAddrs [$];

  word_t romImage [romWords];
  word_t ramModel [1 << ramAddrWidth];
  word_t periphModel [4];

  always #5 romclk = ~romclk;

  memSubsystem #(
    .ramAddrWidth(ramAddrWidth)
  ) i_dut (
    .romclk(romclk),
    .rst   (rst),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .datIn (datIn),
    .datOut(datOut),
    .ack   (ack),
    .tx    (tx)
  );

  memChecker i_checker (
    .romclk    (romclk),
    .rst       (rst),
    .cyc       (cyc),
    .stb       (stb),
    .we        (we),
    .adr       (adr),
    .datOut    (datOut),
    .ack       (ack),
    .tx        (tx),
    .expData   (expData),
    .expTxData (expTxData),
    .txExpected(txExpected),
    .testDone  (testDone),
    .testId    (testId),
    .allDone   (allDone),
    .errors    (errors)
  );

  // Expected read word or the transmitted word for a write
  function automatic word_t refModel(input wordAddr_t a, input logic wr, input word_t d);
    word_t r;
    r = '0;
    if (int'(a) < romWords) begin
      if (!wr) begin
        r = romImage[a[4:0]];
      end
    end else if (int'(a) >= int'(periphBase) && int'(a) < int'(periphBase) + 4) begin
      if (wr) begin
        periphModel[a[1:0]] = d;
        r = d;
      end else begin
        r = periphModel[a[1:0]];
      end
    end else if (int'(a) >= int'(ramBase) &&
                 int'(a) < int'(ramBase) + (1 << ramAddrWidth)) begin
      if (wr) begin
        ramModel[int'(a) - int'(ramBase)] = d;
      end else begin
        r = ramModel[int'(a) - int'(ramBase)];
      end
    end
    return r;
  endfunction

  task automatic busCycle(input wordAddr_t a, input logic wr, input word_t d);
    word_t r;
    int    n;
    logic  got;
    if (!hung) begin
      r = refModel(a, wr, d);
      @(negedge romclk);
      if (wr && a == periphBase) begin
        expTxData  = r;
        txExpected = txExpected + 1;
      end else if (!wr) begin
        expData = r;
      end
      cyc   = 1'b1;
      stb   = 1'b1;
      we    = wr;
      adr   = a;
      datIn = d;
      n     = 0;
      got   = 1'b0;
      while (!got && n < ackTimeout) begin
        @(posedge romclk);
        got = ack;
        n++;
      end
      @(negedge romclk);
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
      if (!got) begin
        $display("No ack within %0d cycles for address %h", ackTimeout, a);
        hung = 1'b1;
      end
    end
  endtask

  task automatic endTest(input int id);
    @(negedge romclk);
    testId   = id;
    testDone = 1'b1;
    @(negedge romclk);
    testDone = 1'b0;
  endtask

  initial begin
    wordAddr_t a;
    int        k;
    romImage = '{16'hF200, 16'h4000, 16'hF800, 16'h1007, 16'hF400, 16'h3050, 16'h7010, 16'h0011,
                 16'h2007, 16'h000B, 16'h7004, 16'h0050, 16'hA007, 16'h9011, 16'hB00B, 16'h7200,
                 16'h7008, 16'h0007, 16'h7080, 16'hF400, 16'h7400, 16'h7040, 16'hF400, 16'h7020,
                 16'h7100, 16'h7040, 16'hF400, 16'h501E, 16'h6051, 16'h7001, 16'h001C, 16'hC01E};
    rst        = 1'b1;
    cyc        = 1'b0;
    stb        = 1'b0;
    we         = 1'b0;
    adr        = '0;
    datIn      = '0;
    expData    = '0;
    expTxData  = '0;
    txExpected = 0;
    testDone   = 1'b0;
    allDone    = 1'b0;
    testId     = 0;
    hung       = 1'b0;
    repeat (10) @(posedge romclk);
    @(negedge romclk);
    rst = 1'b0;
    repeat (3) @(negedge romclk); // Idle bus right after reset
    endTest(1);

    for (int i = 0; i < romWords; i++) begin
      busCycle(wordAddr_t'(i), 1'b0, '0);
    end
    busCycle(12'h005, 1'b1, 16'hDEAD);
    busCycle(12'h005, 1'b0, '0);
    endTest(2);

    for (int i = 0; i < 16; i++) begin
      a = wordAddr_t'(int'(ramBase) + ($unsigned($random(seed)) % (1 << ramAddrWidth)));
      ramAddrs.push_back(a);
      busCycle(a, 1'b1, word_t'($random(seed)));
    end
    for (int i = 0; i < 24; i++) begin
      k = $unsigned($random(seed)) % ramAddrs.size(); // Random order
      busCycle(ramAddrs[k], 1'b0, '0);
    end
    endTest(3);

    for (int i = 0; i < 4; i++) begin
      busCycle(wordAddr_t'(int'(periphBase) + i), 1'b1, word_t'($random(seed)));
    end
    for (int i = 3; i >= 0; i--) begin
      busCycle(wordAddr_t'(int'(periphBase) + i), 1'b0, '0);
    end
    endTest(4);

    busCycle(12'h030, 1'b0, '0);
    busCycle(12'hFFF, 1'b0, '0);
    busCycle(12'h054, 1'b0, '0);
    busCycle(12'h200, 1'b0, '0); // First word past the RAM window
    busCycle(12'h030, 1'b1, 16'h1234);
    busCycle(12'h030, 1'b0, '0);
    endTest(5);

    @(negedge romclk);
    allDone = 1'b1;
    @(negedge romclk);
    allDone = 1'b0;
    if (hung || errors != 0) begin
      $display("Test failed");
    end else begin
      $display("Test passed");
    end
    $finish;
  end

endmodule

/* compile.f */
hdl/memPkg.sv
hdl/wbMemPort.sv
hdl/bootRom.sv
hdl/dataRam.sv
hdl/periphRegs.sv
hdl/memSubsystem.sv
verification/memChecker.sv
verification/memSubsystemTb.sv

/* Bender.yml */
package:
  name: mem_subsystem

sources:
  - files:
      - hdl/memPkg.sv
      - hdl/wbMemPort.sv
      - hdl/bootRom.sv
      - hdl/dataRam.sv
      - hdl/periphRegs.sv
      - hdl/memSubsystem.sv
  - target: test
    files:
      - verification/memChecker.sv
      - verification/memSubsystemTb.sv
